// ==== pic_config.svh ====
// Sizing macros for the 8259A-style interrupt controller
// Include from any package or module that needs line count or bus widths
// The guard lets several files of one compilation unit include it safely
`ifndef PIC_CONFIG_SVH
`define PIC_CONFIG_SVH

// Interrupt request lines IR0..IR7
`define PIC_LINES 8

// Wishbone data bus, one register per address
`define PIC_DATA_W 8

// Wishbone address, selects one of the byte registers
`define PIC_ADR_W 3

`endif

// ==== picIrqPkg.sv ====
// Interrupt-side types shared by the controller core
// Request vectors, level indices and the priority scheme
// Import inside a module body, use scoped names in port lists
`include "pic_config.svh"

package picIrqPkg;

    // One bit per request line, bit 0 is IR0
    typedef logic [`PIC_LINES-1:0] irqVecT;

    // Index of a single level
    typedef logic [$clog2(`PIC_LINES)-1:0] irqLevelT;

    // Fixed: IR0 highest, IR7 lowest
    // Rotate: the level just serviced drops to lowest priority
    typedef enum logic {
        PRIO_FIXED  = 1'b0,
        PRIO_ROTATE = 1'b1
    } prioModeT;

endpackage

// ==== picRegPkg.sv ====
// Wishbone register map of the interrupt controller
// Addresses of the byte registers and bit fields of the configuration word
// Used by the bus controller and by the testbench
`include "pic_config.svh"

package picRegPkg;

    typedef logic [`PIC_ADR_W-1:0] regAdrT;

    localparam regAdrT REG_CONFIG  = 3'd0;  // Mode bits, R/W
    localparam regAdrT REG_VECBASE = 3'd1;  // Vector returned for IR0, R/W
    localparam regAdrT REG_MASK    = 3'd2;  // Interrupt mask, R/W
    localparam regAdrT REG_EOI     = 3'd3;  // Write for non-specific EOI
    localparam regAdrT REG_IRR     = 3'd4;  // Pending requests, read only
    localparam regAdrT REG_ISR     = 3'd5;  // Levels in service, read only
    localparam regAdrT REG_ACK     = 3'd6;  // Read acts as INTA, returns vector

    // Configuration word bits
    localparam int CFG_LTIM   = 3;  // 1 = level triggered, 0 = edge
    localparam int CFG_ROTATE = 4;  // 1 = rotate on EOI

endpackage

// ==== picCoreIf.sv ====
// Status and control bundle between the controller core blocks
// One instance lives in the top level, each block takes its own modport
`timescale 1ns/1ps

interface picCoreIf;
    import picIrqPkg::*;

    irqVecT   requestBits;    // IRR contents
    irqVecT   maskBits;       // IMR contents
    irqVecT   inServiceBits;  // ISR contents
    logic     grantValid;     // A level may interrupt the CPU
    irqLevelT grantLevel;     // Winning pending level
    irqLevelT lowestLevel;    // Level with the lowest priority
    logic     ackPulse;       // Acknowledge read accepted
    logic     eoiPulse;       // EOI write accepted
    irqLevelT eoiLevel;       // Highest-priority level in service
    logic     levelMode;      // LTIM
    logic     rotateMode;     // Rotate priority on EOI

    modport request  (output requestBits,
                      input levelMode, ackPulse, grantLevel);
    modport service  (output inServiceBits,
                      input ackPulse, eoiPulse, grantLevel, eoiLevel);
    modport resolver (output grantValid, grantLevel, eoiLevel,
                      input requestBits, maskBits, inServiceBits, lowestLevel);
    modport rotator  (output lowestLevel,
                      input eoiPulse, eoiLevel, rotateMode);
    modport control  (output maskBits, ackPulse, eoiPulse, levelMode, rotateMode,
                      input grantValid, grantLevel, requestBits, inServiceBits);

endinterface

// ==== interruptRequestRegister.sv ====
// Interrupt request register
// Samples the IR lines once per clock and keeps the previous sample
// Edge mode latches rising edges until the level is acknowledged
// Level mode simply tracks the sampled line state
`timescale 1ns/1ps
`include "pic_config.svh"

module interruptRequestRegister (
    input  logic              readPriority,
    input  logic              resetIRR,
    input  picIrqPkg::irqVecT irLines,
    picCoreIf.request         core
);
    import picIrqPkg::*;

    irqVecT lineSample;  // Lines as seen at the last edge
    irqVecT linePrev;    // One sample older
    irqVecT risingBits;
    irqVecT ackClear;

    assign risingBits = lineSample & ~linePrev;  // Low to high between samples

    // Acknowledge clears only the granted level, and only in edge mode
    always_comb begin
        for (int i = 0; i < `PIC_LINES; i++) begin
            ackClear[i] = core.ackPulse && !core.levelMode
                          && (core.grantLevel == irqLevelT'(i));
        end
    end

    always_ff @(posedge readPriority) begin
        if (resetIRR) begin
            lineSample       <= '0;
            linePrev         <= '0;
            core.requestBits <= '0;
        end else begin
            lineSample <= irLines;
            linePrev   <= lineSample;
            if (core.levelMode) begin
                core.requestBits <= lineSample;  // Follows the line
            end else begin
                // A fresh edge wins over a clear on the same level
                core.requestBits <= (core.requestBits & ~ackClear) | risingBits;
            end
        end
    end

endmodule

// ==== inServiceRegister.sv ====
// In-service register
// A bit is set when its level is acknowledged and stays set until EOI
// While set, it blocks grants of the same and of lower priority levels
`timescale 1ns/1ps
`include "pic_config.svh"

module inServiceRegister (
    input  logic      readPriority,
    input  logic      resetIRR,
    picCoreIf.service core
);
    import picIrqPkg::*;

    irqVecT setBits;    // Level entering service
    irqVecT clearBits;  // Level leaving service

    always_comb begin
        for (int i = 0; i < `PIC_LINES; i++) begin
            setBits[i]   = core.ackPulse && (core.grantLevel == irqLevelT'(i));
            clearBits[i] = core.eoiPulse && (core.eoiLevel == irqLevelT'(i));
        end
    end

    always_ff @(posedge readPriority) begin
        if (resetIRR) begin
            core.inServiceBits <= '0;
        end else begin
            // Pulses are exclusive, order only matters in theory
            core.inServiceBits <= (core.inServiceBits & ~clearBits) | setBits;
        end
    end

endmodule

// ==== priorityRotator.sv ====
// Lowest-priority pointer for the resolver
// Fixed mode pins it to the top level, so IR0 wins
// Rotate mode moves it to the level just released by EOI
`timescale 1ns/1ps
`include "pic_config.svh"

module priorityRotator (
    input  logic      readPriority,
    input  logic      resetIRR,
    picCoreIf.rotator core
);
    localparam logic [2:0] bottomLevel = 3'(`PIC_LINES - 1);  // IR7

    always_ff @(posedge readPriority) begin
        if (resetIRR) begin
            core.lowestLevel <= bottomLevel;
        end else if (!core.rotateMode) begin
            core.lowestLevel <= bottomLevel;  // Back to fixed order
        end else if (core.eoiPulse) begin
            // Serviced level becomes lowest, the next one up becomes highest
            core.lowestLevel <= core.eoiLevel;
        end
    end

endmodule

// ==== priorityResolver.sv ====
// Priority resolver, purely combinational
// Walks the levels from lowestLevel+1 around to lowestLevel
// Picks the first pending unmasked level and the first in-service level
// A grant is only valid if it outranks everything already in service
`timescale 1ns/1ps
`include "pic_config.svh"

module priorityResolver (
    picCoreIf.resolver core
);
    import picIrqPkg::*;

    always_comb begin
        irqVecT   pending;
        irqLevelT lvl;
        irqLevelT reqLevel;
        irqLevelT svcLevel;
        logic     reqFound;
        logic     svcFound;
        logic [3:0] reqRank;  // 0 is highest priority
        logic [3:0] svcRank;

        pending  = core.requestBits & ~core.maskBits;  // Masked lines never win
        reqFound = 1'b0;
        svcFound = 1'b0;
        reqLevel = core.lowestLevel;
        svcLevel = core.lowestLevel;
        reqRank  = 4'(`PIC_LINES);
        svcRank  = 4'(`PIC_LINES);

        for (int i = 1; i <= `PIC_LINES; i++) begin
            lvl = core.lowestLevel + irqLevelT'(i);  // Wraps, last step is lowestLevel
            if (!reqFound && pending[lvl]) begin
                reqFound = 1'b1;
                reqLevel = lvl;
                reqRank  = 4'(i - 1);
            end
            if (!svcFound && core.inServiceBits[lvl]) begin
                svcFound = 1'b1;
                svcLevel = lvl;
                svcRank  = 4'(i - 1);
            end
        end

        core.grantLevel = reqLevel;
        core.grantValid = reqFound && (reqRank < svcRank);  // Equal rank is blocked
        core.eoiLevel   = svcLevel;
    end

endmodule

// ==== busController.sv ====
// Wishbone classic slave and register file of the controller
// Holds configuration, vector base and mask, reads back IRR and ISR
// A read of the acknowledge register stands in for the INTA cycle
// A write of the EOI register ends service of the top ISR level
// ack is one cycle wide, followed by at least one idle cycle
`timescale 1ns/1ps
`include "pic_config.svh"

module busController (
    input  logic                   readPriority,
    input  logic                   resetIRR,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  picRegPkg::regAdrT      adr,
    input  logic [`PIC_DATA_W-1:0] datW,
    output logic [`PIC_DATA_W-1:0] datR,
    output logic                   ack,
    output logic                   intReq,
    picCoreIf.control              core
);
    import picIrqPkg::*;
    import picRegPkg::*;

    typedef enum logic [1:0] {
        stIdle,     // Waiting for cyc and stb
        stRespond,  // ack is high
        stRecover   // Gap before the next transfer
    } busStateT;

    typedef logic [`PIC_DATA_W-1:0] dataT;

    busStateT state;
    dataT     cfgReg;
    dataT     vecBase;
    irqVecT   maskReg;
    prioModeT prioMode;
    logic     request;    // New transfer accepted this edge
    dataT     readData;
    dataT     ackVector;

    assign request = cyc && stb && (state == stIdle);

    // Mode decode from the configuration word
    assign prioMode        = cfgReg[CFG_ROTATE] ? PRIO_ROTATE : PRIO_FIXED;
    assign core.levelMode  = cfgReg[CFG_LTIM];
    assign core.rotateMode = (prioMode == PRIO_ROTATE);
    assign core.maskBits   = maskReg;

    // Spurious acknowledge answers with the IR7 vector
    assign ackVector = core.grantValid ? vecBase + dataT'(core.grantLevel)
                                       : vecBase + dataT'(`PIC_LINES - 1);

    always_comb begin
        case (adr)
            REG_CONFIG:  readData = cfgReg;
            REG_VECBASE: readData = vecBase;
            REG_MASK:    readData = dataT'(maskReg);
            REG_IRR:     readData = dataT'(core.requestBits);
            REG_ISR:     readData = dataT'(core.inServiceBits);
            REG_ACK:     readData = ackVector;
            default:     readData = '0;  // EOI and unused address read zero
        endcase
    end

    always_ff @(posedge readPriority) begin
        if (resetIRR) begin
            state         <= stIdle;
            ack           <= 1'b0;
            intReq        <= 1'b0;
            core.ackPulse <= 1'b0;
            core.eoiPulse <= 1'b0;
            cfgReg        <= '0;  // Edge mode, fixed priority
            vecBase       <= '0;
            maskReg       <= '0;
        end else begin
            ack           <= 1'b0;
            core.ackPulse <= 1'b0;
            core.eoiPulse <= 1'b0;
            intReq        <= core.grantValid;  // One cycle behind the resolver
            case (state)
                stIdle: begin
                    if (request) begin
                        ack   <= 1'b1;
                        state <= stRespond;
                        if (we) begin
                            case (adr)
                                REG_CONFIG:  cfgReg  <= datW;
                                REG_VECBASE: vecBase <= datW;
                                REG_MASK:    maskReg <= irqVecT'(datW);
                                REG_EOI:     core.eoiPulse <= |core.inServiceBits;
                                default:     ;  // Read-only registers ignore writes
                            endcase
                        end else if (adr == REG_ACK) begin
                            core.ackPulse <= core.grantValid;  // No ISR change if spurious
                        end
                    end
                end
                stRespond: state <= stRecover;
                stRecover: state <= stIdle;
                default:   state <= stIdle;
            endcase
        end
    end

    // Read data is only meaningful while ack is high
    always_ff @(posedge readPriority) begin
        if (request && !we) begin
            datR <= readData;
        end
    end

endmodule

// ==== programmableInterruptController.sv ====
// Top level of the 8259A-style interrupt controller
// Wishbone classic slave for the CPU, eight request lines, one interrupt output
// The core blocks talk over a single status bundle
`timescale 1ns/1ps
`include "pic_config.svh"

module programmableInterruptController (
    input  logic                   readPriority,  // Clock
    input  logic                   resetIRR,      // Synchronous reset
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [`PIC_ADR_W-1:0]  adr,
    input  logic [`PIC_DATA_W-1:0] datW,
    output logic [`PIC_DATA_W-1:0] datR,
    output logic                   ack,
    input  logic [`PIC_LINES-1:0]  irLines,
    output logic                   intReq
);
    import picIrqPkg::*;

    picCoreIf coreBus ();

    irqVecT irLinesVec;
    assign irLinesVec = irLines;

    interruptRequestRegister uRequest (
        .readPriority (readPriority),
        .resetIRR     (resetIRR),
        .irLines      (irLinesVec),
        .core         (coreBus.request)
    );

    inServiceRegister uService (
        .readPriority (readPriority),
        .resetIRR     (resetIRR),
        .core         (coreBus.service)
    );

    priorityRotator uRotator (
        .readPriority (readPriority),
        .resetIRR     (resetIRR),
        .core         (coreBus.rotator)
    );

    priorityResolver uResolver (
        .core (coreBus.resolver)
    );

    busController uBus (
        .readPriority (readPriority),
        .resetIRR     (resetIRR),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .datW         (datW),
        .datR         (datR),
        .ack          (ack),
        .intReq       (intReq),
        .core         (coreBus.control)
    );

endmodule

// ==== picChk.sv ====
// Protocol checker for the interrupt controller
// Bound into the top level to watch the Wishbone handshake and the core pulses
// Checks the ack width, the ack cause and the separation of INTA and EOI
`timescale 1ns/1ps

module picChk (
    input logic readPriority,
    input logic resetIRR,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic ackPulse,  // Acknowledge read accepted
    input logic eoiPulse   // EOI write accepted
);

    // The slave drops ack on the very next edge
    ackSingle: assert property (@(posedge readPriority) disable iff (resetIRR)
        ack |=> !ack)
        else $error("ack stayed high for two cycles");

    // A fresh ack needs cyc and stb on the edge before
    ackAfterStb: assert property (@(posedge readPriority) disable iff (resetIRR)
        $rose(ack) |-> $past(cyc && stb))
        else $error("ack raised without cyc and stb");

    // INTA and EOI come from different transfers
    pulseExclusive: assert property (@(posedge readPriority) disable iff (resetIRR)
        !(ackPulse && eoiPulse))
        else $error("ackPulse and eoiPulse high in the same cycle");

endmodule

bind programmableInterruptController picChk uChk (
    .readPriority (readPriority),
    .resetIRR     (resetIRR),
    .cyc          (cyc),
    .stb          (stb),
    .ack          (ack),
    .ackPulse     (coreBus.ackPulse),
    .eoiPulse     (coreBus.eoiPulse)
);

// ==== picTb.sv ====
// Testbench for the 8259A-style interrupt controller
// Applies a table of line changes, Wishbone transfers and intReq checks
// Expected vectors of the rotate test come from a small priority model
`timescale 1ns/1ps
`include "pic_config.svh"

module picTb;
    import picRegPkg::*;

    localparam int OP_LINES = 0;  // Drive irLines and let IRR settle
    localparam int OP_WRITE = 1;
    localparam int OP_READ  = 2;  // Compare datR with the table
    localparam int OP_IRQ   = 3;  // Compare intReq with bit 0 of the table
    localparam int MAX_ROWS = 64;
    localparam logic [7:0] BASE = 8'h20;  // Vector base used throughout

    logic       readPriority;
    logic       resetIRR;
    logic       cyc;
    logic       stb;
    logic       we;
    regAdrT     adr;
    logic [7:0] datW;
    logic [7:0] datR;
    logic       ack;
    logic [7:0] irLines;
    logic       intReq;

    // Stimulus table, one row per step
    int         rowTest [MAX_ROWS];
    int         rowOp   [MAX_ROWS];
    regAdrT     rowAdr  [MAX_ROWS];
    logic [7:0] rowData [MAX_ROWS];
    logic [7:0] rowExp  [MAX_ROWS];
    int         rowCount   = 0;

    int         checks     = 0;
    int         errors     = 0;
    int         testErrors = 0;
    int         cycleCount = 0;
    int         cycleLimit = 40 * MAX_ROWS;  // Narrowed once the table is built
    int         seed       = 32'h7cd4_3c7e;

    programmableInterruptController u_dut (
        .readPriority (readPriority),
        .resetIRR     (resetIRR),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .datW         (datW),
        .datR         (datR),
        .ack          (ack),
        .irLines      (irLines),
        .intReq       (intReq)
    );

    initial begin
        readPriority = 1'b0;
        forever #50 readPriority = ~readPriority;  // 100 ns period
    end

    // Run limit, 40 cycles per table row
    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge readPriority);
            cycleCount++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycleLimit);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic addRow(input int test, input int op, input regAdrT a,
                          input logic [7:0] d, input logic [7:0] e);
        rowTest[rowCount] = test;
        rowOp[rowCount]   = op;
        rowAdr[rowCount]  = a;
        rowData[rowCount] = d;
        rowExp[rowCount]  = e;
        rowCount++;
    endtask

    // First pending level after lowest, wrapping around, 7 when none
    function automatic int nextLevel(input logic [7:0] pending, input int lowest);
        int lvl;
        for (int i = 1; i <= 8; i++) begin
            lvl = (lowest + i) % 8;
            if (pending[lvl]) return lvl;
        end
        return 7;
    endfunction

    task automatic buildTable();
        logic [7:0] pattern;
        logic [7:0] irrAfter;
        int         first;
        int         second;
        // Random lines above IR4, plus IR1 and IR4 always
        pattern  = (8'($random(seed)) & 8'hE0) | 8'h12;
        first    = nextLevel(pattern, 2);  // Lowest is 2 after EOI of level 2
        irrAfter = pattern & ~(8'h01 << first);
        second   = nextLevel(irrAfter, first);

        // 1 Edge mode
        addRow(1, OP_WRITE, REG_VECBASE, BASE, 8'h00);
        addRow(1, OP_READ,  REG_VECBASE, 8'h00, BASE);
        addRow(1, OP_LINES, 3'd0, 8'h28, 8'h00);  // IR3 and IR5
        addRow(1, OP_READ,  REG_IRR, 8'h00, 8'h28);
        addRow(1, OP_IRQ,   3'd0, 8'h00, 8'h01);
        addRow(1, OP_READ,  REG_ACK, 8'h00, BASE + 8'd3);
        addRow(1, OP_READ,  REG_ISR, 8'h00, 8'h08);
        // 2 Masking, IR3 edge again then masked
        addRow(2, OP_WRITE, REG_EOI, 8'h00, 8'h00);
        addRow(2, OP_LINES, 3'd0, 8'h20, 8'h00);
        addRow(2, OP_LINES, 3'd0, 8'h28, 8'h00);
        addRow(2, OP_WRITE, REG_MASK, 8'h08, 8'h00);
        addRow(2, OP_READ,  REG_IRR, 8'h00, 8'h28);  // Masked bit still pending
        addRow(2, OP_READ,  REG_ACK, 8'h00, BASE + 8'd5);
        addRow(2, OP_WRITE, REG_EOI, 8'h00, 8'h00);
        addRow(2, OP_WRITE, REG_MASK, 8'h00, 8'h00);
        // 3 Nesting, IR6 waits behind level 3
        addRow(3, OP_READ,  REG_ACK, 8'h00, BASE + 8'd3);
        addRow(3, OP_READ,  REG_ISR, 8'h00, 8'h08);
        addRow(3, OP_LINES, 3'd0, 8'h68, 8'h00);
        addRow(3, OP_IRQ,   3'd0, 8'h00, 8'h00);
        addRow(3, OP_READ,  REG_IRR, 8'h00, 8'h40);
        addRow(3, OP_WRITE, REG_EOI, 8'h00, 8'h00);
        addRow(3, OP_READ,  REG_ISR, 8'h00, 8'h00);
        addRow(3, OP_IRQ,   3'd0, 8'h00, 8'h01);
        addRow(3, OP_READ,  REG_ACK, 8'h00, BASE + 8'd6);
        addRow(3, OP_WRITE, REG_EOI, 8'h00, 8'h00);
        // 4 Level mode
        addRow(4, OP_LINES, 3'd0, 8'h00, 8'h00);
        addRow(4, OP_WRITE, REG_CONFIG, 8'h08, 8'h00);  // LTIM
        addRow(4, OP_READ,  REG_CONFIG, 8'h00, 8'h08);
        addRow(4, OP_LINES, 3'd0, 8'h11, 8'h00);
        addRow(4, OP_READ,  REG_IRR, 8'h00, 8'h11);
        addRow(4, OP_LINES, 3'd0, 8'h01, 8'h00);
        addRow(4, OP_READ,  REG_IRR, 8'h00, 8'h01);  // IR4 dropped with its line
        addRow(4, OP_IRQ,   3'd0, 8'h00, 8'h01);
        addRow(4, OP_LINES, 3'd0, 8'h00, 8'h00);
        addRow(4, OP_READ,  REG_IRR, 8'h00, 8'h00);
        addRow(4, OP_IRQ,   3'd0, 8'h00, 8'h00);
        // 5 Rotate mode, edge triggered
        addRow(5, OP_WRITE, REG_CONFIG, 8'h10, 8'h00);
        addRow(5, OP_LINES, 3'd0, 8'h04, 8'h00);
        addRow(5, OP_READ,  REG_ACK, 8'h00, BASE + 8'd2);
        addRow(5, OP_LINES, 3'd0, pattern | 8'h04, 8'h00);  // IR2 held, no new edge
        addRow(5, OP_WRITE, REG_EOI, 8'h00, 8'h00);  // Level 2 becomes lowest
        addRow(5, OP_READ,  REG_IRR, 8'h00, pattern);
        addRow(5, OP_READ,  REG_ACK, 8'h00, BASE + 8'(first));
        addRow(5, OP_WRITE, REG_EOI, 8'h00, 8'h00);
        addRow(5, OP_READ,  REG_ACK, 8'h00, BASE + 8'(second));
        addRow(5, OP_WRITE, REG_EOI, 8'h00, 8'h00);
        addRow(5, OP_READ,  REG_ISR, 8'h00, 8'h00);
        // 6 Spurious acknowledge
        addRow(6, OP_LINES, 3'd0, 8'h00, 8'h00);
        addRow(6, OP_WRITE, REG_CONFIG, 8'h08, 8'h00);  // Level mode empties IRR
        addRow(6, OP_READ,  REG_IRR, 8'h00, 8'h00);
        addRow(6, OP_IRQ,   3'd0, 8'h00, 8'h00);
        addRow(6, OP_READ,  REG_ACK, 8'h00, BASE + 8'd7);
        addRow(6, OP_READ,  REG_ISR, 8'h00, 8'h00);
    endtask

    // One Wishbone classic transfer, returns the read data
    task automatic busCycle(input logic wr, input regAdrT a, input logic [7:0] d,
                            output logic [7:0] r);
        @(negedge readPriority);
        cyc  = 1'b1;
        stb  = 1'b1;
        we   = wr;
        adr  = a;
        datW = d;
        @(negedge readPriority);
        while (!ack) @(negedge readPriority);  // Slave may still be recovering
        r   = datR;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic setLines(input logic [7:0] v);
        @(negedge readPriority);
        irLines = v;
        repeat (3) @(negedge readPriority);  // Sample, IRR update, intReq
    endtask

    task automatic reportTest(input int t);
        if (testErrors == 0) begin
            $display("Test %0d ok", t);
        end else begin
            $display("Test %0d: %0d errors", t, testErrors);
        end
        errors     = errors + testErrors;
        testErrors = 0;
    endtask

    initial begin
        logic [7:0] readVal;
        int         lastTest;
        resetIRR = 1'b1;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        datW     = 8'h00;
        irLines  = 8'h00;
        buildTable();
        cycleLimit = 40 * rowCount;
        repeat (2) @(posedge readPriority);
        @(negedge readPriority);
        resetIRR = 1'b0;

        lastTest = rowTest[0];
        for (int r = 0; r < rowCount; r++) begin
            if (rowTest[r] != lastTest) begin
                reportTest(lastTest);
                lastTest = rowTest[r];
            end
            case (rowOp[r])
                OP_LINES: setLines(rowData[r]);
                OP_WRITE: busCycle(1'b1, rowAdr[r], rowData[r], readVal);
                OP_READ: begin
                    busCycle(1'b0, rowAdr[r], 8'h00, readVal);
                    checks++;
                    if (readVal !== rowExp[r]) begin
                        $display("Mismatch datR (test %0d, adr %0d): expected 0x%02h, got 0x%02h",
                                 rowTest[r], rowAdr[r], rowExp[r], readVal);
                        testErrors++;
                    end
                end
                OP_IRQ: begin
                    repeat (3) @(negedge readPriority);  // Registered one cycle late
                    checks++;
                    if (intReq !== rowExp[r][0]) begin
                        $display("Mismatch intReq (test %0d): expected 0x%0h, got 0x%0h",
                                 rowTest[r], rowExp[r][0], intReq);
                        testErrors++;
                    end
                end
                default: ;
            endcase
        end
        reportTest(lastTest);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
picIrqPkg.sv
picRegPkg.sv
picCoreIf.sv
interruptRequestRegister.sv
inServiceRegister.sv
priorityRotator.sv
priorityResolver.sv
busController.sv
programmableInterruptController.sv
picChk.sv
picTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module picTb -o picSim \
    || { echo "Build failed"; exit 1; }

./obj_dir/picSim > sim.log 2>&1 || echo "Simulation FAILED" >> sim.log
cat sim.log

grep -q "Simulation FAILED" sim.log && { echo "Run failed"; exit 1; } || echo "Run passed"
